/* source/rv_exec_pkg.sv */
package rv_exec_pkg;

   localparam int XLEN   = 32;
   localparam int REG_AW = 5;

   // Opcodes kept from the full RV32I set
   localparam logic [6:0] OPC_R   = 7'b0110011;
   localparam logic [6:0] OPC_I   = 7'b0010011;
   localparam logic [6:0] OPC_LUI = 7'b0110111;

   // funct3 for R and I arithmetic
   localparam logic [2:0] F3_ADD  = 3'b000;
   localparam logic [2:0] F3_SLL  = 3'b001;
   localparam logic [2:0] F3_SLT  = 3'b010;
   localparam logic [2:0] F3_SLTU = 3'b011;
   localparam logic [2:0] F3_XOR  = 3'b100;
   localparam logic [2:0] F3_SRX  = 3'b101;
   localparam logic [2:0] F3_OR   = 3'b110;
   localparam logic [2:0] F3_AND  = 3'b111;

   // ALU select, same codes as the CPU's alu_sel
   typedef enum logic [3:0] {
      ALU_ADD    = 4'b0000,
      ALU_SLL    = 4'b0001,
      ALU_SLT    = 4'b0010,
      ALU_SLTU   = 4'b0011,
      ALU_XOR    = 4'b0100,
      ALU_SRL    = 4'b0101,
      ALU_OR     = 4'b0110,
      ALU_AND    = 4'b0111,
      ALU_SUB    = 4'b1100,
      ALU_SRA    = 4'b1101,
      ALU_PASS_B = 4'b1111
   } alu_op_e;

   typedef struct packed {
      logic [6:0]        funct7;
      logic [REG_AW-1:0] rs2;
      logic [REG_AW-1:0] rs1;
      logic [2:0]        funct3;
      logic [REG_AW-1:0] rd;
      logic [6:0]        opcode;
   } inst_r_t;

   typedef struct packed {
      logic [11:0]       imm12;
      logic [REG_AW-1:0] rs1;
      logic [2:0]        funct3;
      logic [REG_AW-1:0] rd;
      logic [6:0]        opcode;
   } inst_i_t;

   // One instruction word, two field layouts
   typedef union packed {
      inst_r_t r;
      inst_i_t i;
   } inst_u;

   typedef struct packed {
      alu_op_e           alu_op;
      logic [REG_AW-1:0] rs1;
      logic [REG_AW-1:0] rs2;
      logic [REG_AW-1:0] rd;
      logic              use_imm;
      logic [XLEN-1:0]   imm;
      logic              illegal;
   } dec_op_t;

   typedef struct packed {
      logic [REG_AW-1:0] rd;
      logic [XLEN-1:0]   value;
      logic              illegal;
   } result_t;

endpackage

/* source/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder import rv_exec_pkg::*; (
   input  logic    clk,
   input  logic    arst_n,
   input  logic    inst_valid,
   input  inst_u   inst,
   output logic    inst_ready,
   output logic    dec_valid,
   output dec_op_t dec_op,
   input  logic    dec_ready
);

   dec_op_t dec_next;
   logic    accept;

   // Output register free or draining this cycle
   assign inst_ready = !dec_valid || dec_ready;
   assign accept     = inst_valid && inst_ready;

   always_comb begin
      dec_next = '0;
      case (inst.r.opcode)
         OPC_R: begin
            dec_next.rs1 = inst.r.rs1;
            dec_next.rs2 = inst.r.rs2;
            dec_next.rd  = inst.r.rd;
            case (inst.r.funct3)
               F3_ADD:  dec_next.alu_op = inst.r.funct7[5] ? ALU_SUB : ALU_ADD;
               F3_SLL:  dec_next.alu_op = ALU_SLL;
               F3_SLT:  dec_next.alu_op = ALU_SLT;
               F3_SLTU: dec_next.alu_op = ALU_SLTU;
               F3_XOR:  dec_next.alu_op = ALU_XOR;
               F3_SRX:  dec_next.alu_op = inst.r.funct7[5] ? ALU_SRA : ALU_SRL;
               F3_OR:   dec_next.alu_op = ALU_OR;
               default: dec_next.alu_op = ALU_AND;
            endcase
         end
         OPC_I: begin
            dec_next.rs1     = inst.i.rs1;
            dec_next.rd      = inst.i.rd;
            dec_next.use_imm = 1'b1;
            dec_next.imm     = {{(XLEN-12){inst.i.imm12[11]}}, inst.i.imm12};
            case (inst.i.funct3)
               F3_ADD:  dec_next.alu_op = ALU_ADD;
               F3_SLT:  dec_next.alu_op = ALU_SLT;
               F3_SLTU: dec_next.alu_op = ALU_SLTU;
               F3_XOR:  dec_next.alu_op = ALU_XOR;
               F3_OR:   dec_next.alu_op = ALU_OR;
               F3_AND:  dec_next.alu_op = ALU_AND;
               F3_SLL: begin
                  dec_next.alu_op = ALU_SLL;
                  dec_next.imm    = {{(XLEN-5){1'b0}}, inst.i.imm12[4:0]};
               end
               default: begin
                  // srli / srai, funct7 bit 5 sits at imm12[10]
                  dec_next.alu_op = inst.i.imm12[10] ? ALU_SRA : ALU_SRL;
                  dec_next.imm    = {{(XLEN-5){1'b0}}, inst.i.imm12[4:0]};
               end
            endcase
         end
         OPC_LUI: begin
            // rs1 stays zero, value comes through pass-B
            dec_next.rd      = inst.i.rd;
            dec_next.use_imm = 1'b1;
            dec_next.alu_op  = ALU_PASS_B;
            dec_next.imm     = {inst.i.imm12, inst.i.rs1, inst.i.funct3, 12'b0};
         end
         default: begin
            dec_next.illegal = 1'b1;
         end
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dec_valid <= 1'b0;
      end else if (inst_ready) begin
         dec_valid <= inst_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         dec_op <= dec_next;
      end
   end

   a_dec_hold: assert property (@(posedge clk) disable iff (!arst_n)
      dec_valid && !dec_ready |=> dec_valid && $stable(dec_op));

endmodule

/* source/op_fifo.sv */
`timescale 1ns/1ps

module op_fifo import rv_exec_pkg::*; #(
   parameter int DEPTH = 4
) (
   input  logic    clk,
   input  logic    arst_n,
   input  logic    in_valid,
   output logic    in_ready,
   input  dec_op_t in_op,
   output logic    out_valid,
   input  logic    out_ready,
   output dec_op_t out_op
);

   localparam int AW = $clog2(DEPTH);
   localparam logic [AW:0] FULL_CNT = (AW+1)'(DEPTH);

   if (DEPTH < 2 || (DEPTH & (DEPTH - 1)) != 0) begin : g_depth_check
      $error("op_fifo DEPTH must be a power of two, 2 or more");
   end

   dec_op_t       mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;
   logic          push;
   logic          pop;

   // A pop in the same cycle frees the slot for a push
   assign in_ready  = (count != FULL_CNT) || out_ready;
   assign out_valid = (count != '0);
   assign out_op    = mem[rd_ptr];

   assign push = in_valid && in_ready;
   assign pop  = out_valid && out_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_op;
      end
   end

   a_count_max: assert property (@(posedge clk) disable iff (!arst_n)
      count <= FULL_CNT);

   // Pointers must also show a stored entry at every pop
   a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
      pop |-> (rd_ptr != wr_ptr) || (count == FULL_CNT));

endmodule

/* source/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit import rv_exec_pkg::*; (
   input  logic    clk,
   input  logic    arst_n,
   input  logic    op_valid,
   output logic    op_ready,
   input  dec_op_t op,
   output logic    res_valid,
   input  logic    res_ready,
   output result_t res
);

   logic [XLEN-1:0] rf [2**REG_AW];
   logic [XLEN-1:0] a;
   logic [XLEN-1:0] rs2_val;
   logic [XLEN-1:0] b;
   logic [4:0]      shamt;
   logic [XLEN-1:0] alu_out;
   logic            accept;
   logic            wr_en;

   // Result register empty or being taken
   assign op_ready = !res_valid || res_ready;
   assign accept   = op_valid && op_ready;
   assign wr_en    = accept && !op.illegal && (op.rd != '0);

   // Operand fetch and B select
   assign a       = rf[op.rs1];
   assign rs2_val = rf[op.rs2];
   assign b       = op.use_imm ? op.imm : rs2_val;
   assign shamt   = b[4:0];

   always_comb begin
      case (op.alu_op)
         ALU_ADD:    alu_out = a + b;
         ALU_SUB:    alu_out = a - b;
         ALU_SLL:    alu_out = a << shamt;
         ALU_SLT:    alu_out = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
         ALU_SLTU:   alu_out = {{(XLEN-1){1'b0}}, a < b};
         ALU_XOR:    alu_out = a ^ b;
         ALU_SRL:    alu_out = a >> shamt;
         ALU_SRA:    alu_out = $unsigned($signed(a) >>> shamt);
         ALU_OR:     alu_out = a | b;
         ALU_AND:    alu_out = a & b;
         ALU_PASS_B: alu_out = b;
         default:    alu_out = '0;
      endcase
   end

   // Writeback shares the edge that loads the result
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         res_valid <= 1'b0;
         for (int i = 0; i < 2**REG_AW; i++) begin
            rf[i] <= '0;
         end
      end else begin
         if (accept) begin
            res_valid <= 1'b1;
         end else if (res_ready) begin
            res_valid <= 1'b0;
         end
         if (wr_en) begin
            rf[op.rd] <= alu_out;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         res.rd      <= op.rd;
         res.value   <= op.illegal ? '0 : alu_out;
         res.illegal <= op.illegal;
      end
   end

   // x0 is hardwired, whatever rd the decoder sends
   a_x0_zero: assert property (@(posedge clk) disable iff (!arst_n)
      rf[0] == '0);

   a_res_hold: assert property (@(posedge clk) disable iff (!arst_n)
      res_valid && !res_ready |=> res_valid && $stable(res));

endmodule

/* source/rv_exec_core.sv */
`timescale 1ns/1ps

module rv_exec_core import rv_exec_pkg::*; #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        inst_valid,
   output logic        inst_ready,
   input  logic [31:0] inst,
   output logic        res_valid,
   input  logic        res_ready,
   output result_t     res
);

   // Decoder to FIFO
   logic    dec_valid;
   logic    dec_ready;
   dec_op_t dec_op;

   // FIFO to execute
   logic    fifo_valid;
   logic    fifo_ready;
   dec_op_t fifo_op;

   inst_decoder u_inst_decoder (
      .clk        (clk),
      .arst_n     (arst_n),
      .inst_valid (inst_valid),
      .inst       (inst),
      .inst_ready (inst_ready),
      .dec_valid  (dec_valid),
      .dec_op     (dec_op),
      .dec_ready  (dec_ready)
   );

   op_fifo #(
      .DEPTH (FIFO_DEPTH)
   ) u_op_fifo (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (dec_valid),
      .in_ready  (dec_ready),
      .in_op     (dec_op),
      .out_valid (fifo_valid),
      .out_ready (fifo_ready),
      .out_op    (fifo_op)
   );

   exec_unit u_exec_unit (
      .clk       (clk),
      .arst_n    (arst_n),
      .op_valid  (fifo_valid),
      .op_ready  (fifo_ready),
      .op        (fifo_op),
      .res_valid (res_valid),
      .res_ready (res_ready),
      .res       (res)
   );

endmodule

/* verification/tb_rv_exec_core.sv */
`timescale 1ns/1ps

module tb_rv_exec_core import rv_exec_pkg::*; ();

   localparam int XLEN       = 32;
   localparam int FIFO_DEPTH = 4;
   localparam int N_RAND     = 40;
   // Instructions issued over all tests
   localparam int N_TOTAL    = 31 + 80 + 3 + 17 + (FIFO_DEPTH + 2) + N_RAND + 4;
   localparam int MAX_CYCLES = 20 * N_TOTAL + 200;
   localparam logic [4:0]  PAIR_A [4] = '{5'd1, 5'd2, 5'd4, 5'd0};
   localparam logic [4:0]  PAIR_B [4] = '{5'd4, 5'd3, 5'd1, 5'd4};
   localparam logic [11:0] IMMS [4]   = '{12'hFFF, 12'h800, 12'h005, 12'h7FF};

   logic        clk;
   logic        arst_n;
   logic        inst_valid;
   logic        inst_ready;
   logic [31:0] inst;
   logic        res_valid;
   logic        res_ready = 1'b1;
   result_t     res;

   // Reference model state and expected results in issue order
   logic [XLEN-1:0] mregs [32];
   result_t         exp_q [$];
   result_t         exp_head = '0;
   int              exp_rd = 0;
   int              exp_cnt = 0;
   int              errors = 0;
   int              checks = 0;
   int              cycles = 0;
   integer          seed = 76913;
   logic [63:0]     ready_pat;
   int              ready_mode = 0;   // 0 ready, 1 stalled, 2 random

   rv_exec_core #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_rv_exec_core (
      .clk        (clk),
      .arst_n     (arst_n),
      .inst_valid (inst_valid),
      .inst_ready (inst_ready),
      .inst       (inst),
      .res_valid  (res_valid),
      .res_ready  (res_ready),
      .res        (res)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: tests still running after %0d cycles", MAX_CYCLES);
         $display("Finished with errors");
         $finish;
      end
   end

   // Result consumed, move to the next expected entry
   always @(posedge clk) begin
      if (arst_n && res_valid && res_ready && exp_cnt != 0) begin
         exp_rd <= exp_rd + 1;
         checks <= checks + 1;
      end
   end

   always @(negedge clk) begin
      exp_head <= (exp_q.size() > exp_rd) ? exp_q[exp_rd] : '0;
      exp_cnt  <= exp_q.size() - exp_rd;
      case (ready_mode)
         0: res_ready = 1'b1;
         1: res_ready = 1'b0;
         default: res_ready = ready_pat[cycles[5:0]];
      endcase
   end

   a_res_value: assert property (@(posedge clk) disable iff (!arst_n)
      res_valid && res_ready && exp_cnt != 0 |-> res == exp_head)
      else begin
         $display("CHECK FAILED at %0t: result {rd,value,illegal} %h, expected %h",
            $time, $sampled(res), $sampled(exp_head));
         errors++;
      end

   a_res_expected: assert property (@(posedge clk) disable iff (!arst_n)
      res_valid && res_ready |-> exp_cnt != 0)
      else begin
         $display("Result at %0t arrived with no instruction outstanding", $time);
         errors++;
      end

   a_res_stable: assert property (@(posedge clk) disable iff (!arst_n)
      res_valid && !res_ready |=> $stable(res))
      else begin
         $display("CHECK FAILED at %0t: result changed while stalled", $time);
         errors++;
      end

   function automatic logic [31:0] r_word(logic alt, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
      return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_R};
   endfunction

   function automatic logic [31:0] i_word(logic [11:0] imm, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
      return {imm, rs1, f3, rd, OPC_I};
   endfunction

   // Executes one word on the model registers, returns the expected result
   function automatic result_t model_exec(logic [31:0] w);
      result_t     r;
      logic [31:0] a;
      logic [31:0] b;
      logic [4:0]  sh;
      logic        alt;
      r   = '0;
      a   = mregs[w[19:15]];
      b   = (w[6:0] == OPC_R) ? mregs[w[24:20]] : {{20{w[31]}}, w[31:20]};
      sh  = b[4:0];
      alt = w[30];
      r.rd = w[11:7];
      case (w[6:0])
         OPC_LUI: r.value = {w[31:12], 12'b0};
         OPC_R, OPC_I: begin
            case (w[14:12])
               F3_ADD:  r.value = (w[6:0] == OPC_R && alt) ? a - b : a + b;
               F3_SLL:  r.value = a << sh;
               F3_SLT:  r.value = {31'b0, $signed(a) < $signed(b)};
               F3_SLTU: r.value = {31'b0, a < b};
               F3_XOR:  r.value = a ^ b;
               F3_SRX: begin
                  // Arithmetic shift fills with the sign bit
                  if (alt) begin
                     r.value = $signed(a) >>> sh;
                  end else begin
                     r.value = a >> sh;
                  end
               end
               F3_OR:   r.value = a | b;
               default: r.value = a & b;
            endcase
         end
         default: begin
            r.rd      = '0;
            r.illegal = 1'b1;
         end
      endcase
      if (!r.illegal && r.rd != '0) begin
         mregs[r.rd] = r.value;
      end
      return r;
   endfunction

   function automatic logic [31:0] random_word();
      logic [31:0] r;
      logic [2:0]  f3;
      logic [11:0] imm;
      r   = $random(seed);
      f3  = r[15:13];
      imm = r[28:17];
      if (f3 == F3_SLL) imm = {7'b0, imm[4:0]};
      if (f3 == F3_SRX) imm = {1'b0, r[16], 5'b0, imm[4:0]};
      if (r[0]) begin
         return r_word(r[16] && (f3 == F3_ADD || f3 == F3_SRX), {1'b0, r[8:5]},
                       {1'b0, r[4:1]}, f3, {1'b0, r[12:9]});
      end
      return i_word(imm, {1'b0, r[4:1]}, f3, {1'b0, r[12:9]});
   endfunction

   // Called at a falling edge, returns at the falling edge after the handshake
   task automatic issue(input logic [31:0] w);
      inst_valid = 1'b1;
      inst       = w;
      #1;
      while (!inst_ready) begin
         @(negedge clk);
         #1;
      end
      exp_q.push_back(model_exec(w));
      @(negedge clk);
      inst_valid = 1'b0;
   endtask

   task automatic drain();
      while (exp_q.size() != exp_rd) begin
         @(negedge clk);
      end
   endtask

   task automatic test_done(input string name);
      drain();
      $display("Test %s done, errors so far %0d", name, errors);
   endtask

   initial begin
      logic [11:0] imm;
      logic [4:0]  rs1;
      int          n;
      arst_n     = 1'b0;
      inst_valid = 1'b0;
      inst       = '0;
      for (int i = 0; i < 32; i++) begin
         mregs[i] = '0;
      end
      repeat (10) @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);

      assert (!res_valid && inst_ready) else begin
         $display("CHECK FAILED at %0t: handshake outputs wrong after reset", $time);
         errors++;
      end
      for (int i = 1; i < 32; i++) begin
         issue(r_word(1'b0, 5'd0, 5'(i), F3_ADD, 5'(i)));
      end
      test_done("reset");

      issue(i_word(12'hFF9, 5'd0, F3_ADD, 5'd1));
      issue({20'h80000, 5'd2, OPC_LUI});
      // Shift count above 31
      issue(i_word(12'd37, 5'd0, F3_ADD, 5'd3));
      issue(i_word(12'h5A5, 5'd0, F3_ADD, 5'd4));
      for (int k = 0; k < 10; k++) begin
         for (int p = 0; p < 4; p++) begin
            issue(r_word(k >= 8, PAIR_B[p], PAIR_A[p],
                         (k < 8) ? 3'(k) : ((k == 8) ? F3_ADD : F3_SRX), 5'd8));
         end
      end
      for (int k = 0; k < 8; k++) begin
         for (int j = 0; j < 4; j++) begin
            imm = (k == 1 || k == 5) ? {7'b0, IMMS[j][4:0]} : IMMS[j];
            rs1 = j[0] ? 5'd2 : 5'd1;
            issue(i_word(imm, rs1, 3'(k), 5'd9));
            if (k == 5) issue(i_word(imm | 12'h400, rs1, 3'(k), 5'd9));
         end
      end
      test_done("alu");

      issue(i_word(12'd5, 5'd1, F3_ADD, 5'd0));
      issue({20'hABCDE, 5'd0, OPC_LUI});
      issue(r_word(1'b0, 5'd0, 5'd0, F3_ADD, 5'd9));
      test_done("x0");

      issue(i_word(12'd1, 5'd0, F3_ADD, 5'd10));
      for (int k = 0; k < 16; k++) begin
         if (k[0]) issue(i_word(12'hFFD, 5'd10, F3_ADD, 5'd10));
         else issue(r_word(1'b0, 5'd10, 5'd10, F3_ADD, 5'd10));
      end
      test_done("chain");

      ready_mode = 1;
      repeat (2) @(negedge clk);
      n = 0;
      while (inst_ready) begin
         issue(i_word(12'd1, 5'd11, F3_ADD, 5'd11));
         n++;
      end
      assert (n <= FIFO_DEPTH + 2) else begin
         $display("CHECK FAILED at %0t: %0d instructions taken while stalled", $time, n);
         errors++;
      end
      repeat (8) @(negedge clk);
      ready_pat  = {$random(seed), $random(seed)};
      ready_mode = 2;
      for (int k = 0; k < N_RAND; k++) begin
         issue(random_word());
      end
      drain();
      ready_mode = 0;
      test_done("back-pressure");

      // Load and jal opcodes fall outside the kept set
      issue({12'h123, 5'd1, 3'b010, 5'd12, 7'b0000011});
      issue({20'h12345, 5'd13, 7'b1101111});
      issue(r_word(1'b0, 5'd0, 5'd12, F3_ADD, 5'd14));
      issue(r_word(1'b0, 5'd0, 5'd13, F3_ADD, 5'd15));
      test_done("illegal");

      $display("Checks passed %0d, errors %0d", checks - errors, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

/* src.f */
source/rv_exec_pkg.sv
source/inst_decoder.sv
source/op_fifo.sv
source/exec_unit.sv
source/rv_exec_core.sv
verification/tb_rv_exec_core.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the rv_exec_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rv_exec_core -f src.f -o tb_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/tb_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "Finished with no errors"; then
   exit 0
fi
exit 1
